/* src/noc_topo_pkg.sv */
// Mesh topology definitions for the routers and the top level: port directions and XY routing
package noc_topo_pkg;

   // Router port directions, also used as port indices
   typedef enum logic [2:0] {
      DIR_NORTH = 3'd0,
      DIR_EAST  = 3'd1,
      DIR_SOUTH = 3'd2,
      DIR_WEST  = 3'd3,
      DIR_LOCAL = 3'd4
   } dir_e;

   localparam int PORTS = 5;

   // Dimension-ordered routing, X first and then Y
   // Row 0 is the northern edge, column 0 the western edge
   function automatic dir_e xy_route(input int x_size, input int cur, input int dest);
      int   cur_x;
      int   cur_y;
      int   dest_x;
      int   dest_y;
      dir_e dir;
      cur_x  = cur % x_size;
      cur_y  = cur / x_size;
      dest_x = dest % x_size;
      dest_y = dest / x_size;
      if (dest_x < cur_x) begin
         dir = DIR_WEST;
      end else if (dest_x > cur_x) begin
         dir = DIR_EAST;
      end else if (dest_y < cur_y) begin
         dir = DIR_NORTH;
      end else if (dest_y > cur_y) begin
         dir = DIR_SOUTH;
      end else begin
         dir = DIR_LOCAL;
      end
      return dir;
   endfunction

endpackage

/* src/noc_flit_pkg.sv */
// Flit and link types of the NoC, with the header field layout used by routers and endpoints
package noc_flit_pkg;

   localparam int FLIT_WIDTH = 32;
   localparam int NODE_WIDTH = 8;

   // Header layout: destination in the low byte, source in the byte above
   localparam int DEST_LSB = 0;
   localparam int SRC_LSB  = NODE_WIDTH;

   typedef struct packed {
      logic                  last;
      logic [FLIT_WIDTH-1:0] data;
   } flit_t;

   // Forward half of a link, ready runs the other way
   typedef struct packed {
      logic  valid;
      flit_t flit;
   } link_t;

   function automatic logic [NODE_WIDTH-1:0] dest_of(input logic [FLIT_WIDTH-1:0] data);
      return data[DEST_LSB +: NODE_WIDTH];
   endfunction

   // Routers ignore the source, endpoints use it to match packets
   function automatic logic [NODE_WIDTH-1:0] src_of(input logic [FLIT_WIDTH-1:0] data);
      return data[SRC_LSB +: NODE_WIDTH];
   endfunction

endpackage

/* src/noc_input_port.sv */
// Router input stage: buffers incoming flits and offers the head flit with its XY route
`timescale 1ns/1ps

module noc_input_port #(
   parameter int X            = 2,
   parameter int NODE         = 0,
   parameter int BUFFER_DEPTH = 4
) (
   input  logic                clk,
   input  logic                rst,
   input  noc_flit_pkg::link_t in_link,
   output logic                in_ready,
   output noc_flit_pkg::flit_t head,
   output logic                head_valid,
   output noc_topo_pkg::dir_e  route,
   input  logic                pop
);

   localparam int AW = (BUFFER_DEPTH > 1) ? $clog2(BUFFER_DEPTH) : 1;
   localparam int CW = $clog2(BUFFER_DEPTH + 1);

   typedef enum logic {
      ST_HEADER,
      ST_PACKET
   } state_e;

   noc_flit_pkg::flit_t mem [BUFFER_DEPTH];
   logic [AW-1:0]       wr_ptr;
   logic [AW-1:0]       rd_ptr;
   logic [CW-1:0]       count;
   logic                push;
   logic                do_pop;
   state_e              state;
   noc_topo_pkg::dir_e  route_hdr;
   noc_topo_pkg::dir_e  route_q;

   // Pointer increment that also handles depths that are not a power of two
   function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
      if (ptr == AW'(BUFFER_DEPTH - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   assign in_ready   = (count != CW'(BUFFER_DEPTH));
   assign push       = in_link.valid && in_ready;
   assign head_valid = (count != '0);
   assign head       = mem[rd_ptr];
   assign do_pop     = pop && head_valid;

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= in_link.flit;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (do_pop) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         count <= count + CW'(push) - CW'(do_pop);
      end
   end

   // Route of the flit at the head, valid only while it is a header
   assign route_hdr = noc_topo_pkg::xy_route(X, NODE, int'(noc_flit_pkg::dest_of(head.data)));
   assign route     = (state == ST_HEADER) ? route_hdr : route_q;

   // Body flits follow the route their header took
   always_ff @(posedge clk) begin
      if (rst) begin
         state   <= ST_HEADER;
         route_q <= noc_topo_pkg::DIR_LOCAL;
      end else if (do_pop) begin
         if (state == ST_HEADER) begin
            route_q <= route_hdr;
         end
         state <= head.last ? ST_HEADER : ST_PACKET;
      end
   end

endmodule

/* src/noc_output_arbiter.sv */
// Router output stage: round-robin choice among the input ports, wormhole lock, registered link
`timescale 1ns/1ps

module noc_output_arbiter (
   input  logic                                          clk,
   input  logic                                          rst,
   input  logic                [noc_topo_pkg::PORTS-1:0] req,
   input  noc_flit_pkg::flit_t [noc_topo_pkg::PORTS-1:0] req_flit,
   output logic                [noc_topo_pkg::PORTS-1:0] grant_pop,
   output noc_flit_pkg::link_t                           out_link,
   input  logic                                          out_ready
);

   localparam int SEL_W = $clog2(noc_topo_pkg::PORTS);

   logic [SEL_W-1:0]    last_sel;
   logic [SEL_W-1:0]    lock_sel;
   logic [SEL_W-1:0]    rr_sel;
   logic [SEL_W-1:0]    sel;
   logic                rr_found;
   logic                locked;
   logic                any_req;
   logic                can_load;
   logic                grant;
   logic                out_valid;
   noc_flit_pkg::flit_t out_flit;

   // Search starts at the port after the previous winner
   always_comb begin
      int idx;
      rr_sel   = last_sel;
      rr_found = 1'b0;
      for (int i = 1; i <= noc_topo_pkg::PORTS; i++) begin
         idx = (int'(last_sel) + i) % noc_topo_pkg::PORTS;
         if (!rr_found && req[idx]) begin
            rr_found = 1'b1;
            rr_sel   = SEL_W'(idx);
         end
      end
   end

   // While a packet is in flight only its input may send
   assign sel      = locked ? lock_sel : rr_sel;
   assign any_req  = locked ? req[lock_sel] : rr_found;
   assign can_load = !out_valid || out_ready;
   assign grant    = any_req && can_load;

   always_comb begin
      grant_pop = '0;
      if (grant) begin
         grant_pop[sel] = 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         out_valid <= 1'b0;
         locked    <= 1'b0;
         lock_sel  <= '0;
         last_sel  <= SEL_W'(noc_topo_pkg::PORTS - 1);
      end else if (grant) begin
         out_valid <= 1'b1;
         locked    <= !req_flit[sel].last;
         lock_sel  <= sel;
         last_sel  <= sel;
      end else if (out_ready) begin
         out_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (grant) begin
         out_flit <= req_flit[sel];
      end
   end

   assign out_link = '{valid: out_valid, flit: out_flit};

endmodule

/* src/noc_router.sv */
// One mesh router: five input ports and five output arbiters joined by a crossbar
`timescale 1ns/1ps

module noc_router #(
   parameter int X            = 2,
   parameter int Y            = 2,
   parameter int NODE         = 0,
   parameter int BUFFER_DEPTH = 4
) (
   input  logic                                          clk,
   input  logic                                          rst,
   input  noc_flit_pkg::link_t [noc_topo_pkg::PORTS-1:0] in_link,
   output logic                [noc_topo_pkg::PORTS-1:0] in_ready,
   output noc_flit_pkg::link_t [noc_topo_pkg::PORTS-1:0] out_link,
   input  logic                [noc_topo_pkg::PORTS-1:0] out_ready
);

   localparam int P = noc_topo_pkg::PORTS;

   // Ports that face a neighbor, the local port always counts
   function automatic logic [P-1:0] active_ports(input int node);
      logic [P-1:0] act;
      act = '0;
      act[noc_topo_pkg::DIR_NORTH] = (node / X) > 0;
      act[noc_topo_pkg::DIR_SOUTH] = (node / X) < (Y - 1);
      act[noc_topo_pkg::DIR_WEST]  = (node % X) > 0;
      act[noc_topo_pkg::DIR_EAST]  = (node % X) < (X - 1);
      act[noc_topo_pkg::DIR_LOCAL] = 1'b1;
      return act;
   endfunction

   localparam logic [P-1:0] ACTIVE = active_ports(NODE);

   noc_flit_pkg::flit_t [P-1:0] head;
   logic [P-1:0]                head_valid;
   noc_topo_pkg::dir_e          route [P];
   logic [P-1:0]                pop;
   // Indexed [output][input]
   logic [P-1:0][P-1:0]         xbar_req;
   logic [P-1:0][P-1:0]         xbar_pop;

   for (genvar i = 0; i < P; i++) begin : g_in
      noc_input_port #(
         .X            (X),
         .NODE         (NODE),
         .BUFFER_DEPTH (BUFFER_DEPTH)
      ) u_input_port (
         .clk        (clk),
         .rst        (rst),
         .in_link    (in_link[i]),
         .in_ready   (in_ready[i]),
         .head       (head[i]),
         .head_valid (head_valid[i]),
         .route      (route[i]),
         .pop        (pop[i])
      );
   end

   // Each output only sees the inputs whose route names it
   always_comb begin
      for (int o = 0; o < P; o++) begin
         for (int i = 0; i < P; i++) begin
            xbar_req[o][i] = head_valid[i] && ACTIVE[i] &&
                             (route[i] == noc_topo_pkg::dir_e'(o));
         end
      end
   end

   // At most one arbiter grants a given input
   always_comb begin
      pop = '0;
      for (int o = 0; o < P; o++) begin
         pop = pop | xbar_pop[o];
      end
   end

   for (genvar o = 0; o < P; o++) begin : g_out
      noc_output_arbiter u_output_arbiter (
         .clk       (clk),
         .rst       (rst),
         .req       (xbar_req[o]),
         .req_flit  (head),
         .grant_pop (xbar_pop[o]),
         .out_link  (out_link[o]),
         .out_ready (out_ready[o])
      );
   end

endmodule

/* src/noc_mesh.sv */
// Top level of the NoC: X by Y routers with neighbor links, border tie-offs and one endpoint per node
`timescale 1ns/1ps

module noc_mesh #(
   parameter int X            = 2,
   parameter int Y            = 2,
   parameter int BUFFER_DEPTH = 4
) (
   input  logic                                clk,
   input  logic                                rst,
   input  noc_flit_pkg::link_t [X*Y-1:0]       in_link,
   output logic                [X*Y-1:0]       in_ready,
   output noc_flit_pkg::link_t [X*Y-1:0]       out_link,
   input  logic                [X*Y-1:0]       out_ready
);

   localparam int NODES = X * Y;
   localparam int P     = noc_topo_pkg::PORTS;

   // Per router and port, seen from the router
   wire noc_flit_pkg::link_t [NODES-1:0][P-1:0] node_in_link;
   wire noc_flit_pkg::link_t [NODES-1:0][P-1:0] node_out_link;
   wire [NODES-1:0][P-1:0]                      node_in_ready;
   wire [NODES-1:0][P-1:0]                      node_out_ready;

   for (genvar y = 0; y < Y; y++) begin : g_y
      for (genvar x = 0; x < X; x++) begin : g_x
         localparam int N = x + y * X;

         noc_router #(
            .X            (X),
            .Y            (Y),
            .NODE         (N),
            .BUFFER_DEPTH (BUFFER_DEPTH)
         ) u_router (
            .clk       (clk),
            .rst       (rst),
            .in_link   (node_in_link[N]),
            .in_ready  (node_in_ready[N]),
            .out_link  (node_out_link[N]),
            .out_ready (node_out_ready[N])
         );

         // Local endpoint
         assign node_in_link[N][noc_topo_pkg::DIR_LOCAL]   = in_link[N];
         assign in_ready[N]                                = node_in_ready[N][noc_topo_pkg::DIR_LOCAL];
         assign out_link[N]                                = node_out_link[N][noc_topo_pkg::DIR_LOCAL];
         assign node_out_ready[N][noc_topo_pkg::DIR_LOCAL] = out_ready[N];

         if (y > 0) begin : g_north
            assign node_in_link[N][noc_topo_pkg::DIR_NORTH] =
               node_out_link[N-X][noc_topo_pkg::DIR_SOUTH];
            assign node_out_ready[N][noc_topo_pkg::DIR_NORTH] =
               node_in_ready[N-X][noc_topo_pkg::DIR_SOUTH];
         end else begin : g_north_edge
            assign node_in_link[N][noc_topo_pkg::DIR_NORTH]   = '0;
            assign node_out_ready[N][noc_topo_pkg::DIR_NORTH] = 1'b1;
         end

         if (y < Y - 1) begin : g_south
            assign node_in_link[N][noc_topo_pkg::DIR_SOUTH] =
               node_out_link[N+X][noc_topo_pkg::DIR_NORTH];
            assign node_out_ready[N][noc_topo_pkg::DIR_SOUTH] =
               node_in_ready[N+X][noc_topo_pkg::DIR_NORTH];
         end else begin : g_south_edge
            assign node_in_link[N][noc_topo_pkg::DIR_SOUTH]   = '0;
            assign node_out_ready[N][noc_topo_pkg::DIR_SOUTH] = 1'b1;
         end

         if (x > 0) begin : g_west
            assign node_in_link[N][noc_topo_pkg::DIR_WEST] =
               node_out_link[N-1][noc_topo_pkg::DIR_EAST];
            assign node_out_ready[N][noc_topo_pkg::DIR_WEST] =
               node_in_ready[N-1][noc_topo_pkg::DIR_EAST];
         end else begin : g_west_edge
            assign node_in_link[N][noc_topo_pkg::DIR_WEST]   = '0;
            assign node_out_ready[N][noc_topo_pkg::DIR_WEST] = 1'b1;
         end

         if (x < X - 1) begin : g_east
            assign node_in_link[N][noc_topo_pkg::DIR_EAST] =
               node_out_link[N+1][noc_topo_pkg::DIR_WEST];
            assign node_out_ready[N][noc_topo_pkg::DIR_EAST] =
               node_in_ready[N+1][noc_topo_pkg::DIR_WEST];
         end else begin : g_east_edge
            assign node_in_link[N][noc_topo_pkg::DIR_EAST]   = '0;
            assign node_out_ready[N][noc_topo_pkg::DIR_EAST] = 1'b1;
         end
      end
   end

endmodule

/* tb/noc_clock_gen.sv */
// Clock and reset source for the NoC testbench, instantiated once by the testbench top
`timescale 1ns/1ps

module noc_clock_gen #(
   parameter int PERIOD_NS    = 8,
   parameter int RESET_CYCLES = 4
) (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   // Reset is released on a rising edge, so the DUT sees it synchronously
   initial begin
      rst <= 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      rst <= 1'b0;
   end

endmodule

/* tb/noc_mesh_sva.sv */
// Concurrent assertions for the router output stage that are bound into every output arbiter
`timescale 1ns/1ps

module noc_mesh_sva (
   input logic                                           clk,
   input logic                                           rst,
   input noc_flit_pkg::flit_t [noc_topo_pkg::PORTS-1:0]  req_flit,
   input logic                [noc_topo_pkg::PORTS-1:0]  grant_pop,
   input noc_flit_pkg::link_t                            out_link,
   input logic                                           out_ready
);

   logic [noc_topo_pkg::PORTS-1:0] open_port;
   logic                           granted_last;

   // Last flag of the flit popped in this cycle
   always_comb begin
      granted_last = 1'b0;
      for (int i = 0; i < noc_topo_pkg::PORTS; i++) begin
         if (grant_pop[i] && req_flit[i].last) begin
            granted_last = 1'b1;
         end
      end
   end

   // Input whose packet has started on this output and not yet ended
   always_ff @(posedge clk) begin
      if (rst) begin
         open_port <= '0;
      end else if (grant_pop != '0) begin
         open_port <= granted_last ? '0 : grant_pop;
      end
   end

   // At most one input popped per cycle, and only the input of an unfinished packet
   a_grant_onehot_locked : assert property (
      @(posedge clk) disable iff (rst)
      $onehot0(grant_pop) && (open_port == '0 || (grant_pop & ~open_port) == '0)
   ) else $error("Output arbiter grant %b breaks the packet of input %b", grant_pop, open_port);

   // A flit that is not taken stays on the link unchanged
   a_hold_when_stalled : assert property (
      @(posedge clk) disable iff (rst)
      (out_link.valid && !out_ready) |=> $stable(out_link)
   ) else $error("Output link changed while valid and not ready");

   // Registered output is empty once reset has been seen
   a_no_valid_in_reset : assert property (
      @(posedge clk)
      rst |=> !out_link.valid
   ) else $error("Output link valid during reset");

endmodule

bind noc_output_arbiter noc_mesh_sva u_arbiter_sva (
   .clk       (clk),
   .rst       (rst),
   .req_flit  (req_flit),
   .grant_pop (grant_pop),
   .out_link  (out_link),
   .out_ready (out_ready)
);

/* tb/tb_noc_mesh.sv */
// Testbench of the 3 by 2 NoC mesh that injects a packet table and checks every ejected flit
`timescale 1ns/1ps

module tb_noc_mesh;

   localparam int X            = 3;
   localparam int Y            = 2;
   localparam int NODES        = X * Y;
   localparam int BUFFER_DEPTH = 4;
   localparam int NUM_PKTS     = 22;

   typedef struct packed {
      logic [7:0] src;
      logic [7:0] dst;
      logic [7:0] len;
      logic       stall;
   } pkt_t;

   // Source, destination, length in flits, destination stalls
   localparam pkt_t PKTS [NUM_PKTS] = '{
      // Local loopback at every node
      '{8'd0, 8'd0, 8'd1, 1'b0}, '{8'd1, 8'd1, 8'd1, 1'b0}, '{8'd2, 8'd2, 8'd1, 1'b0},
      '{8'd3, 8'd3, 8'd1, 1'b0}, '{8'd4, 8'd4, 8'd1, 1'b0}, '{8'd5, 8'd5, 8'd1, 1'b0},
      // Across the mesh with corners included
      '{8'd0, 8'd5, 8'd4, 1'b0}, '{8'd5, 8'd0, 8'd4, 1'b0}, '{8'd2, 8'd3, 8'd3, 1'b0},
      '{8'd3, 8'd2, 8'd5, 1'b0}, '{8'd1, 8'd4, 8'd2, 1'b0}, '{8'd4, 8'd1, 8'd3, 1'b0},
      '{8'd0, 8'd2, 8'd6, 1'b0},
      // Long packets converging on node 4
      '{8'd0, 8'd4, 8'd16, 1'b0}, '{8'd2, 8'd4, 8'd16, 1'b0},
      '{8'd3, 8'd4, 8'd16, 1'b0}, '{8'd5, 8'd4, 8'd16, 1'b0},
      // Packets of one pair that must keep their order
      '{8'd1, 8'd5, 8'd2, 1'b0}, '{8'd1, 8'd5, 8'd3, 1'b0}, '{8'd1, 8'd5, 8'd1, 1'b0},
      // Node 3 throttles its ejection port
      '{8'd1, 8'd3, 8'd24, 1'b1}, '{8'd5, 8'd3, 8'd20, 1'b1}
   };

   logic                             clk;
   logic                             rst;
   noc_flit_pkg::link_t [NODES-1:0]  in_link;
   logic                [NODES-1:0]  in_ready;
   noc_flit_pkg::link_t [NODES-1:0]  out_link;
   logic                [NODES-1:0]  out_ready;

   noc_flit_pkg::flit_t exp_q [NODES*NODES][$];
   noc_flit_pkg::flit_t inj_q [NODES][$];
   logic [NODES-1:0]    stall_node = '0;
   logic [NODES-1:0]    stall_src  = '0;
   logic [NODES-1:0]    low_seen   = '0;
   logic [NODES-1:0]    in_pkt     = '0;
   int                  cur_pair [NODES];
   int                  total_flits = 0;
   int                  rx_count    = 0;
   int                  seed        = 32'h061259bd;

   noc_clock_gen #(.PERIOD_NS(8), .RESET_CYCLES(4)) u_clock_gen (.clk(clk), .rst(rst));

   noc_mesh #(
      .X            (X),
      .Y            (Y),
      .BUFFER_DEPTH (BUFFER_DEPTH)
   ) noc_mesh_inst (
      .clk       (clk),
      .rst       (rst),
      .in_link   (in_link),
      .in_ready  (in_ready),
      .out_link  (out_link),
      .out_ready (out_ready)
   );

   task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                              input string what);
      if (actual !== expected) begin
         $display("FAILED at %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
         $display("TEST FAIL");
         $fatal(1, "value mismatch");
      end
   endtask

   // Builds the flits and then drives sources and ejection ready every cycle
   initial begin
      noc_flit_pkg::flit_t fl;
      int                  pair;
      int                  limit;
      int                  cycle;
      in_link   <= '0;
      out_ready <= '1;
      for (int p = 0; p < NUM_PKTS; p++) begin
         pair = int'(PKTS[p].src) * NODES + int'(PKTS[p].dst);
         for (int f = 0; f < int'(PKTS[p].len); f++) begin
            fl.last = (f == int'(PKTS[p].len) - 1);
            if (f == 0) begin
               // Header carries the table index above source and destination
               fl.data = {16'(p), PKTS[p].src, PKTS[p].dst};
            end else begin
               fl.data = $random(seed);
            end
            exp_q[pair].push_back(fl);
            inj_q[PKTS[p].src].push_back(fl);
         end
         total_flits += int'(PKTS[p].len);
         if (PKTS[p].stall) begin
            stall_node[PKTS[p].dst] = 1'b1;
            stall_src[PKTS[p].src]  = 1'b1;
         end
      end
      limit = 40 * total_flits + 200;
      cycle = 0;
      forever begin
         @(posedge clk);
         if (!rst) begin
            cycle++;
            if (cycle > limit) begin
               $display("Timeout after %0d cycles, %0d of %0d flits received",
                        cycle, rx_count, total_flits);
               $display("TEST FAIL");
               $fatal(1, "timeout");
            end else begin
               for (int s = 0; s < NODES; s++) begin
                  if (in_link[s].valid) begin
                     if (in_ready[s]) begin
                        void'(inj_q[s].pop_front());
                     end else begin
                        low_seen[s] = 1'b1;
                     end
                  end
                  if (inj_q[s].size() > 0) begin
                     in_link[s] <= '{valid: 1'b1, flit: inj_q[s][0]};
                  end else begin
                     in_link[s] <= '0;
                  end
               end
               // Stalling nodes accept only in the last quarter of each 48 cycles
               for (int d = 0; d < NODES; d++) begin
                  out_ready[d] <= !stall_node[d] || ((cycle % 48) >= 36);
               end
            end
         end
      end
   end

   // Scoreboard where the header names the source queue for the whole packet
   always @(posedge clk) begin
      noc_flit_pkg::flit_t got;
      noc_flit_pkg::flit_t want;
      int                  src;
      if (!rst) begin
         for (int d = 0; d < NODES; d++) begin
            if (out_link[d].valid && out_ready[d]) begin
               got = out_link[d].flit;
               if (!in_pkt[d]) begin
                  src         = int'(noc_flit_pkg::src_of(got.data));
                  cur_pair[d] = (src < NODES) ? src * NODES + d : -1;
               end
               if (cur_pair[d] < 0 || exp_q[cur_pair[d]].size() == 0) begin
                  $display("Node %0d ejected a flit that no packet in the table accounts for",
                           d);
                  $display("TEST FAIL");
                  $fatal(1, "unexpected flit");
               end else begin
                  want = exp_q[cur_pair[d]].pop_front();
                  check_value(64'(got), 64'(want),
                              $sformatf("flit at node %0d from source %0d",
                                        d, cur_pair[d] / NODES));
                  in_pkt[d] = !got.last;
                  rx_count++;
               end
            end
         end
      end
   end

   initial begin
      wait (total_flits > 0 && rx_count == total_flits);
      @(posedge clk);
      // Nothing may still sit in an output register once every packet is in
      for (int d = 0; d < NODES; d++) begin
         check_value(64'(out_link[d].valid), 64'd0,
                     $sformatf("output valid at node %0d after the last flit", d));
      end
      for (int s = 0; s < NODES; s++) begin
         if (stall_src[s]) begin
            check_value(64'(low_seen[s]), 64'd1,
                        $sformatf("in_ready low seen at source %0d", s));
         end
      end
      $display("TEST PASS");
      $finish;
   end

endmodule

/* sources.f */
src/noc_topo_pkg.sv
src/noc_flit_pkg.sv
src/noc_input_port.sv
src/noc_output_arbiter.sv
src/noc_router.sv
src/noc_mesh.sv
tb/noc_clock_gen.sv
tb/noc_mesh_sva.sv
tb/tb_noc_mesh.sv

/* run.sh */
#!/bin/sh
# Builds the mesh testbench with Verilator and runs it; the exit status is the test result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 \
   --top-module tb_noc_mesh \
   -f sources.f \
   -Mdir obj_dir -o tb_noc_mesh &&
./obj_dir/tb_noc_mesh ||
{ echo "Build or simulation of the NoC mesh did not succeed"; exit 1; }
